// ==== source/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // raster positions
    typedef logic [10:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // frame index inside one second of video
    typedef logic [5:0] frame_count_t;

    // pixel data, red in the top byte and blue in the bottom byte
    typedef logic [7:0] color_t;
    typedef logic [23:0] rgb_t;
    typedef logic [9:0] tmds_word_t;

    // game timer and seven-segment display
    typedef logic [5:0] seconds_t;
    // active low cathodes, segment a in bit 0
    typedef logic [6:0] segments_t;

    typedef enum logic [1:0] {
        TIMER_IDLE,
        TIMER_RUNNING,
        TIMER_DONE
    } timer_state_t;

    // cycles from the counters until the frame buffer returns the pixel
    parameter int VIDEO_PIPE_STAGES_DEFAULT = 4;

endpackage

`default_nettype wire

// ==== source/video_timing.sv ====
`default_nettype none
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT = 110,
    parameter int H_SYNC = 40,
    parameter int H_BACK = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT = 5,
    parameter int V_SYNC = 5,
    parameter int V_BACK = 20,
    parameter int FRAMES_PER_SECOND = 60
) (
    input wire clk_pixel,
    input wire sys_rst,
    output display_pkg::hcount_t hcount,
    output display_pkg::vcount_t vcount,
    output logic hsync,
    output logic vsync,
    output logic active_draw,
    output logic new_frame,
    output display_pkg::frame_count_t frame_count
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    // sync windows sit right after the front porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic line_end;
    logic frame_end;
    logic last_frame_of_second;

    assign line_end = (hcount == display_pkg::hcount_t'(H_TOTAL - 1));
    assign frame_end = (vcount == display_pkg::vcount_t'(V_TOTAL - 1));
    assign last_frame_of_second =
        (frame_count == display_pkg::frame_count_t'(FRAMES_PER_SECOND - 1));

    // raster counters, vcount steps on each hcount wrap
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            vcount <= frame_end ? '0 : vcount + display_pkg::vcount_t'(1);
        end else begin
            hcount <= hcount + display_pkg::hcount_t'(1);
        end
    end

    // decodes straight off the counters
    assign active_draw = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign hsync = (hcount >= H_SYNC_START) && (hcount < H_SYNC_START + H_SYNC);
    assign vsync = (vcount >= V_SYNC_START) && (vcount < V_SYNC_START + V_SYNC);
    // first blanking pixel after the last active line
    assign new_frame = (hcount == H_ACTIVE) && (vcount == V_ACTIVE);

    // frames within the current second
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            frame_count <= '0;
        end else if (new_frame) begin
            frame_count <= last_frame_of_second ? '0
                                                : frame_count + display_pkg::frame_count_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== source/tmds_encoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module tmds_encoder (
    input wire clk_pixel,
    input wire sys_rst,
    input wire display_pkg::color_t data,
    input wire [1:0] control,
    input wire video_enable,
    output display_pkg::tmds_word_t tmds
);
    logic [3:0] data_ones;
    logic [3:0] qm_ones;
    logic use_xnor;
    logic [8:0] q_m;
    // disparity bookkeeping, positive means more ones sent
    logic signed [4:0] disparity;
    logic signed [4:0] disparity_next;
    logic signed [4:0] ones_s;
    logic signed [4:0] zeros_s;
    logic signed [4:0] diff;
    display_pkg::tmds_word_t word_next;

    always_comb begin
        data_ones = '0;
        for (int i = 0; i < 8; i++) begin
            data_ones = data_ones + {3'b000, data[i]};
        end
    end

    // pick xnor when it gives fewer transitions
    assign use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);

    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;
    end

    always_comb begin
        qm_ones = '0;
        for (int i = 0; i < 8; i++) begin
            qm_ones = qm_ones + {3'b000, q_m[i]};
        end
    end

    assign ones_s = $signed({1'b0, qm_ones});
    assign zeros_s = 5'sd8 - ones_s;
    // ones minus zeros of the minimised byte
    assign diff = ones_s - zeros_s;

    // dc balancing, invert when it pulls the disparity back toward zero
    always_comb begin
        if ((disparity == 5'sd0) || (diff == 5'sd0)) begin
            word_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disparity_next = q_m[8] ? disparity + diff : disparity - diff;
        end else if (((disparity > 5'sd0) && (diff > 5'sd0)) ||
                     ((disparity < 5'sd0) && (diff < 5'sd0))) begin
            word_next = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - diff;
        end else begin
            word_next = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + diff;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            tmds <= '0;
            disparity <= '0;
        end else if (video_enable) begin
            tmds <= word_next;
            disparity <= disparity_next;
        end else begin
            // blanking sends a control token and restarts the balance
            disparity <= '0;
            case (control)
                2'b00: tmds <= 10'b1101010100;
                2'b01: tmds <= 10'b0010101011;
                2'b10: tmds <= 10'b0101010100;
                default: tmds <= 10'b1010101011;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/hdmi_encode.sv ====
`default_nettype none
`timescale 1ns/100ps

module hdmi_encode #(
    parameter int VIDEO_PIPE_STAGES = 4
) (
    input wire clk_pixel,
    input wire sys_rst,
    input wire hsync,
    input wire vsync,
    input wire active_draw,
    input wire display_pkg::rgb_t pixel_rgb,
    output display_pkg::tmds_word_t tmds_red,
    output display_pkg::tmds_word_t tmds_green,
    output display_pkg::tmds_word_t tmds_blue
);
    // {vsync, hsync, active_draw} per stage, index 0 is the newest
    logic [2:0] ctrl_pipe [VIDEO_PIPE_STAGES];
    logic [2:0] ctrl_aligned;

    // hold the timing levels until the frame buffer pixel shows up
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            for (int i = 0; i < VIDEO_PIPE_STAGES; i++) begin
                ctrl_pipe[i] <= '0;
            end
        end else begin
            ctrl_pipe[0] <= {vsync, hsync, active_draw};
            for (int i = 1; i < VIDEO_PIPE_STAGES; i++) begin
                ctrl_pipe[i] <= ctrl_pipe[i-1];
            end
        end
    end

    assign ctrl_aligned = ctrl_pipe[VIDEO_PIPE_STAGES-1];

    // red and green only ever carry control 0
    tmds_encoder u_enc_red (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .data(pixel_rgb[23:16]),
        .control(2'b00),
        .video_enable(ctrl_aligned[0]),
        .tmds(tmds_red)
    );

    tmds_encoder u_enc_green (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .data(pixel_rgb[15:8]),
        .control(2'b00),
        .video_enable(ctrl_aligned[0]),
        .tmds(tmds_green)
    );

    // syncs ride on blue during blanking
    tmds_encoder u_enc_blue (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .data(pixel_rgb[7:0]),
        .control(ctrl_aligned[2:1]),
        .video_enable(ctrl_aligned[0]),
        .tmds(tmds_blue)
    );

endmodule

`default_nettype wire

// ==== source/game_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module game_timer #(
    parameter int TIMER_SECONDS = 60,
    parameter int FRAMES_PER_SECOND = 60
) (
    input wire clk_pixel,
    input wire sys_rst,
    input wire start_timer,
    input wire new_frame,
    input wire display_pkg::frame_count_t frame_count,
    output display_pkg::seconds_t time_left,
    output logic timer_done
);
    display_pkg::timer_state_t state;
    logic second_tick;

    // one pulse per second, on the last frame of the second
    assign second_tick = new_frame &&
        (frame_count == display_pkg::frame_count_t'(FRAMES_PER_SECOND - 1));

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            state <= display_pkg::TIMER_IDLE;
            time_left <= '0;
        end else if (start_timer) begin
            // start or restart from any state
            state <= display_pkg::TIMER_RUNNING;
            time_left <= display_pkg::seconds_t'(TIMER_SECONDS);
        end else begin
            case (state)
                display_pkg::TIMER_RUNNING: begin
                    if (second_tick) begin
                        if (time_left <= display_pkg::seconds_t'(1)) begin
                            time_left <= '0;
                            state <= display_pkg::TIMER_DONE;
                        end else begin
                            time_left <= time_left - display_pkg::seconds_t'(1);
                        end
                    end
                end
                // idle and done wait for a start
                default: state <= state;
            endcase
        end
    end

    // done holds until the next start pulse
    assign timer_done = (state == display_pkg::TIMER_DONE);

endmodule

`default_nettype wire

// ==== source/seven_segment_controller.sv ====
`default_nettype none
`timescale 1ns/100ps

module seven_segment_controller #(
    parameter int REFRESH_DIV = 1024
) (
    input wire clk_pixel,
    input wire sys_rst,
    input wire display_pkg::seconds_t value,
    output display_pkg::segments_t cathodes,
    output logic [1:0] anodes
);
    localparam int REFRESH_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

    logic [REFRESH_W-1:0] refresh_count;
    logic show_tens;
    logic [3:0] tens_digit;
    logic [3:0] ones_digit;
    logic [3:0] shown_digit;

    // active low patterns, bit 0 is segment a
    function automatic display_pkg::segments_t digit_to_segments(input logic [3:0] digit);
        display_pkg::segments_t pattern;
        case (digit)
            4'd0: pattern = 7'b1000000;
            4'd1: pattern = 7'b1111001;
            4'd2: pattern = 7'b0100100;
            4'd3: pattern = 7'b0110000;
            4'd4: pattern = 7'b0011001;
            4'd5: pattern = 7'b0010010;
            4'd6: pattern = 7'b0000010;
            4'd7: pattern = 7'b1111000;
            4'd8: pattern = 7'b0000000;
            4'd9: pattern = 7'b0010000;
            default: pattern = 7'b1111111;
        endcase
        return pattern;
    endfunction

    // decimal split, value never exceeds 63
    assign tens_digit = 4'(value / 6'd10);
    assign ones_digit = 4'(value % 6'd10);
    assign shown_digit = show_tens ? tens_digit : ones_digit;

    // swap digits every REFRESH_DIV cycles, ones first
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            refresh_count <= '0;
            show_tens <= 1'b0;
        end else if (refresh_count == REFRESH_W'(REFRESH_DIV - 1)) begin
            refresh_count <= '0;
            show_tens <= ~show_tens;
        end else begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    // anodes and segments registered together so they never mismatch
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            anodes <= 2'b11;
            cathodes <= 7'b1111111;
        end else begin
            anodes <= show_tens ? 2'b01 : 2'b10;
            cathodes <= digit_to_segments(shown_digit);
        end
    end

endmodule

`default_nettype wire

// ==== source/display_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module display_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT = 110,
    parameter int H_SYNC = 40,
    parameter int H_BACK = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT = 5,
    parameter int V_SYNC = 5,
    parameter int V_BACK = 20,
    parameter int FRAMES_PER_SECOND = 60,
    parameter int TIMER_SECONDS = 60,
    parameter int REFRESH_DIV = 1024,
    parameter int VIDEO_PIPE_STAGES = display_pkg::VIDEO_PIPE_STAGES_DEFAULT
) (
    input wire clk_pixel,
    input wire sys_rst,
    input wire display_pkg::rgb_t pixel_rgb,
    input wire start_timer,
    output wire display_pkg::hcount_t hcount,
    output wire display_pkg::vcount_t vcount,
    output wire display_pkg::tmds_word_t tmds_red,
    output wire display_pkg::tmds_word_t tmds_green,
    output wire display_pkg::tmds_word_t tmds_blue,
    output wire display_pkg::seconds_t time_left,
    output wire timer_done,
    output wire display_pkg::segments_t cathodes,
    output wire [1:0] anodes
);
    // timing generator to encoder and timer
    wire hsync;
    wire vsync;
    wire active_draw;
    wire new_frame;
    wire display_pkg::frame_count_t frame_count;

    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK),
        .FRAMES_PER_SECOND(FRAMES_PER_SECOND)
    ) u_timing (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .hcount(hcount),
        .vcount(vcount),
        .hsync(hsync),
        .vsync(vsync),
        .active_draw(active_draw),
        .new_frame(new_frame),
        .frame_count(frame_count)
    );

    // pixel_rgb comes back from the frame buffer VIDEO_PIPE_STAGES late
    hdmi_encode #(
        .VIDEO_PIPE_STAGES(VIDEO_PIPE_STAGES)
    ) u_hdmi (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .hsync(hsync),
        .vsync(vsync),
        .active_draw(active_draw),
        .pixel_rgb(pixel_rgb),
        .tmds_red(tmds_red),
        .tmds_green(tmds_green),
        .tmds_blue(tmds_blue)
    );

    game_timer #(
        .TIMER_SECONDS(TIMER_SECONDS),
        .FRAMES_PER_SECOND(FRAMES_PER_SECOND)
    ) u_timer (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .start_timer(start_timer),
        .new_frame(new_frame),
        .frame_count(frame_count),
        .time_left(time_left),
        .timer_done(timer_done)
    );

    // seconds remaining on the two digit display
    seven_segment_controller #(
        .REFRESH_DIV(REFRESH_DIV)
    ) u_segments (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .value(time_left),
        .cathodes(cathodes),
        .anodes(anodes)
    );

endmodule

`default_nettype wire

// ==== tests/display_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module display_tb;
    // small raster so a frame is only 98 cycles
    localparam int H_ACTIVE = 8;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 2;
    localparam int H_BACK = 2;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 1;
    localparam int V_BACK = 1;
    localparam int FRAMES_PER_SECOND = 2;
    localparam int TIMER_SECONDS = 3;
    localparam int REFRESH_DIV = 4;
    localparam int VIDEO_PIPE_STAGES = 4;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int SECOND_CYCLES = FRAME_CYCLES * FRAMES_PER_SECOND;
    localparam int RASTER_CYCLES = 3 * FRAME_CYCLES;
    localparam int START_WAIT_MAX = 64;
    // a full second so the second start lands after the first decrement
    localparam int RESTART_GAP = SECOND_CYCLES;
    localparam int HOLD_CYCLES = 50;
    localparam int DONE_LIMIT = (TIMER_SECONDS + 1) * SECOND_CYCLES;
    localparam int COUNTDOWN_CYCLES = START_WAIT_MAX + 2 + DONE_LIMIT + HOLD_CYCLES;
    localparam int RESTART_CYCLES = 4 + RESTART_GAP + START_WAIT_MAX + DONE_LIMIT;
    localparam int WATCHDOG_CYCLES = 2 + RASTER_CYCLES + COUNTDOWN_CYCLES + RESTART_CYCLES + 200;
    localparam logic [31:0] SEED = 32'h397936cd;

    logic clk_pixel = 1'b0;
    logic sys_rst;
    logic start_timer;
    display_pkg::rgb_t pixel_rgb;
    wire display_pkg::hcount_t hcount;
    wire display_pkg::vcount_t vcount;
    wire display_pkg::tmds_word_t tmds_red;
    wire display_pkg::tmds_word_t tmds_green;
    wire display_pkg::tmds_word_t tmds_blue;
    wire display_pkg::seconds_t time_left;
    wire timer_done;
    wire display_pkg::segments_t cathodes;
    wire [1:0] anodes;

    // raster, timer and display model state
    int h_pos;
    int v_pos;
    int frame_index;
    display_pkg::timer_state_t model_state;
    int seconds_left;
    int refresh_count;
    bit show_tens;
    logic [1:0] exp_anodes;
    display_pkg::segments_t exp_cathodes;
    // reference encoder state per channel
    display_pkg::tmds_word_t exp_red;
    display_pkg::tmds_word_t exp_green;
    display_pkg::tmds_word_t exp_blue;
    int disp_red;
    int disp_green;
    int disp_blue;
    bit aligned_active;
    // {vsync, hsync, active_draw} history with the oldest at the front
    logic [2:0] ctrl_queue [$];
    display_pkg::rgb_t prev_pixel;
    bit prev_start;
    bit start_request;
    logic [31:0] rng_state;
    bit video_checks;
    int timer_test;
    int cycle;
    int wait_cycles;
    int total_errors;
    int failed_tests;
    string test_names [6] = '{"raster", "tmds_data", "tmds_control", "countdown", "restart",
                              "display"};
    int test_errors [6];

    display_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK),
        .FRAMES_PER_SECOND(FRAMES_PER_SECOND),
        .TIMER_SECONDS(TIMER_SECONDS),
        .REFRESH_DIV(REFRESH_DIV),
        .VIDEO_PIPE_STAGES(VIDEO_PIPE_STAGES)
    ) u_display_top (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .pixel_rgb(pixel_rgb),
        .start_timer(start_timer),
        .hcount(hcount),
        .vcount(vcount),
        .tmds_red(tmds_red),
        .tmds_green(tmds_green),
        .tmds_blue(tmds_blue),
        .time_left(time_left),
        .timer_done(timer_done),
        .cathodes(cathodes),
        .anodes(anodes)
    );

    // 100 ns pixel clock
    always #50 clk_pixel = ~clk_pixel;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // {vsync, hsync, active_draw} for a raster position
    function automatic logic [2:0] timing_levels(input int h, input int v);
        logic hs;
        logic vs;
        logic ad;
        ad = (h < H_ACTIVE) && (v < V_ACTIVE);
        hs = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        vs = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        return {vs, hs, ad};
    endfunction

    // DVI control period characters
    function automatic display_pkg::tmds_word_t control_token(input logic [1:0] c);
        display_pkg::tmds_word_t t;
        case (c)
            2'b00: t = 10'b1101010100;
            2'b01: t = 10'b0010101011;
            2'b10: t = 10'b0101010100;
            default: t = 10'b1010101011;
        endcase
        return t;
    endfunction

    // DVI 1.0 video data encoding where disp counts ones minus zeros sent so far
    function automatic display_pkg::tmds_word_t encode_pixel(input logic [7:0] d,
                                                             inout int disp);
        logic [8:0] qm;
        display_pkg::tmds_word_t word;
        int n1_q;
        int n0_q;
        bit xnor_mode;
        xnor_mode = ($countones(d) > 4) || (($countones(d) == 4) && (d[0] == 1'b0));
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xnor_mode ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnor_mode;
        n1_q = $countones(qm[7:0]);
        n0_q = 8 - n1_q;
        if ((disp == 0) || (n1_q == n0_q)) begin
            word = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp = qm[8] ? disp + n1_q - n0_q : disp + n0_q - n1_q;
        end else if (((disp > 0) && (n1_q > n0_q)) || ((disp < 0) && (n0_q > n1_q))) begin
            word = {1'b1, qm[8], ~qm[7:0]};
            disp = disp + (qm[8] ? 2 : 0) + n0_q - n1_q;
        end else begin
            word = {1'b0, qm[8], qm[7:0]};
            disp = disp - (qm[8] ? 0 : 2) + n1_q - n0_q;
        end
        return word;
    endfunction

    // lit segments gfedcba inverted for the active low cathodes
    function automatic display_pkg::segments_t segment_pattern(input int digit);
        logic [6:0] lit;
        case (digit)
            0: lit = 7'h3f;
            1: lit = 7'h06;
            2: lit = 7'h5b;
            3: lit = 7'h4f;
            4: lit = 7'h66;
            5: lit = 7'h6d;
            6: lit = 7'h7d;
            7: lit = 7'h07;
            8: lit = 7'h7f;
            9: lit = 7'h6f;
            default: lit = 7'h00;
        endcase
        return ~lit;
    endfunction

    task automatic report_mismatch(input int id, input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error %s %s at cycle %0d: expected %0h, actual %0h", test_names[id], what,
                 cycle, expected, actual);
        test_errors[id]++;
    endtask

    task automatic reset_models();
        h_pos = 0;
        v_pos = 0;
        frame_index = 0;
        model_state = display_pkg::TIMER_IDLE;
        seconds_left = 0;
        refresh_count = 0;
        show_tens = 1'b0;
        exp_anodes = 2'b11;
        exp_cathodes = 7'h7f;
        exp_red = '0;
        exp_green = '0;
        exp_blue = '0;
        disp_red = 0;
        disp_green = 0;
        disp_blue = 0;
        aligned_active = 1'b0;
        prev_pixel = '0;
        prev_start = 1'b0;
        // delay line comes out of reset full of zeros
        ctrl_queue.delete();
        repeat (VIDEO_PIPE_STAGES) ctrl_queue.push_back(3'b000);
        ctrl_queue.push_back(timing_levels(0, 0));
    endtask

    // advance every model across one rising edge
    task automatic step_models();
        logic [2:0] aligned;
        bit frame_start;
        int fc_old;
        int tl_old;
        bit tens_old;
        frame_start = (h_pos == H_ACTIVE) && (v_pos == V_ACTIVE);
        fc_old = frame_index;
        tl_old = seconds_left;
        tens_old = show_tens;
        // timing levels lined up with the late pixel
        aligned = ctrl_queue.pop_front();
        aligned_active = aligned[0];
        if (aligned[0]) begin
            exp_red = encode_pixel(prev_pixel[23:16], disp_red);
            exp_green = encode_pixel(prev_pixel[15:8], disp_green);
            exp_blue = encode_pixel(prev_pixel[7:0], disp_blue);
        end else begin
            exp_red = control_token(2'b00);
            exp_green = control_token(2'b00);
            exp_blue = control_token(aligned[2:1]);
            disp_red = 0;
            disp_green = 0;
            disp_blue = 0;
        end
        if (h_pos == H_TOTAL - 1) begin
            h_pos = 0;
            v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
        end else begin
            h_pos = h_pos + 1;
        end
        if (frame_start) begin
            frame_index = (fc_old == FRAMES_PER_SECOND - 1) ? 0 : fc_old + 1;
        end
        // countdown on the last frame of each second
        if (prev_start) begin
            model_state = display_pkg::TIMER_RUNNING;
            seconds_left = TIMER_SECONDS;
        end else if ((model_state == display_pkg::TIMER_RUNNING) && frame_start &&
                     (fc_old == FRAMES_PER_SECOND - 1)) begin
            seconds_left = seconds_left - 1;
            if (seconds_left == 0) begin
                model_state = display_pkg::TIMER_DONE;
            end
        end
        // digit shown follows the select held before the edge
        exp_anodes = tens_old ? 2'b01 : 2'b10;
        exp_cathodes = segment_pattern(tens_old ? tl_old / 10 : tl_old % 10);
        if (refresh_count == REFRESH_DIV - 1) begin
            refresh_count = 0;
            show_tens = !show_tens;
        end else begin
            refresh_count = refresh_count + 1;
        end
        ctrl_queue.push_back(timing_levels(h_pos, v_pos));
    endtask

    task automatic check_outputs();
        int tmds_test;
        bit exp_done;
        tmds_test = aligned_active ? 1 : 2;
        exp_done = (model_state == display_pkg::TIMER_DONE);
        if (video_checks) begin
            if (hcount !== display_pkg::hcount_t'(h_pos)) begin
                report_mismatch(0, "hcount", 32'(h_pos), 32'(hcount));
            end
            if (vcount !== display_pkg::vcount_t'(v_pos)) begin
                report_mismatch(0, "vcount", 32'(v_pos), 32'(vcount));
            end
            if (tmds_red !== exp_red) begin
                report_mismatch(tmds_test, "tmds_red", 32'(exp_red), 32'(tmds_red));
            end
            if (tmds_green !== exp_green) begin
                report_mismatch(tmds_test, "tmds_green", 32'(exp_green), 32'(tmds_green));
            end
            if (tmds_blue !== exp_blue) begin
                report_mismatch(tmds_test, "tmds_blue", 32'(exp_blue), 32'(tmds_blue));
            end
        end
        if (time_left !== display_pkg::seconds_t'(seconds_left)) begin
            report_mismatch(timer_test, "time_left", 32'(seconds_left), 32'(time_left));
        end
        if (timer_done !== exp_done) begin
            report_mismatch(timer_test, "timer_done", 32'(exp_done), 32'(timer_done));
        end
        if (anodes !== exp_anodes) begin
            report_mismatch(5, "anodes", 32'(exp_anodes), 32'(anodes));
        end
        if (cathodes !== exp_cathodes) begin
            report_mismatch(5, "cathodes", 32'(exp_cathodes), 32'(cathodes));
        end
        if ((cycle > 0) && (anodes !== 2'b01) && (anodes !== 2'b10)) begin
            $display("display: anodes %b are not one-hot low at cycle %0d", anodes, cycle);
            test_errors[5]++;
        end
    endtask

    // new inputs a little after the edge
    task automatic drive_inputs();
        rng_state = xorshift32(rng_state);
        pixel_rgb = rng_state[23:0];
        start_timer = start_request;
        prev_pixel = rng_state[23:0];
        prev_start = start_request;
        start_request = 1'b0;
    endtask

    task automatic run_cycle();
        @(posedge clk_pixel);
        #10;
        step_models();
        cycle++;
        check_outputs();
        drive_inputs();
    endtask

    // start pulse and then the cycle where the timer has taken it
    task automatic pulse_start(input int id);
        start_request = 1'b1;
        run_cycle();
        run_cycle();
        if (time_left !== display_pkg::seconds_t'(TIMER_SECONDS)) begin
            report_mismatch(id, "time_left after start", 32'(TIMER_SECONDS), 32'(time_left));
        end
        if (timer_done !== 1'b0) begin
            report_mismatch(id, "timer_done after start", 32'(0), 32'(timer_done));
        end
    endtask

    task automatic wait_for_done(input int id);
        int waited;
        waited = 0;
        while ((timer_done !== 1'b1) && (waited < DONE_LIMIT)) begin
            run_cycle();
            waited++;
        end
        if (timer_done !== 1'b1) begin
            $display("%s: timer_done did not rise within %0d cycles", test_names[id],
                     DONE_LIMIT);
            test_errors[id]++;
        end
    endtask

    task automatic finish_test(input int id);
        $display("test %s: %s, %0d errors", test_names[id],
                 (test_errors[id] == 0) ? "ok" : "bad", test_errors[id]);
        total_errors += test_errors[id];
        if (test_errors[id] != 0) begin
            failed_tests++;
        end
    endtask

    // hang guard sized from the test lengths
    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        sys_rst = 1'b1;
        start_timer = 1'b0;
        pixel_rgb = '0;
        start_request = 1'b0;
        rng_state = SEED;
        video_checks = 1'b1;
        timer_test = 3;
        cycle = 0;
        total_errors = 0;
        failed_tests = 0;
        reset_models();
        repeat (2) @(posedge clk_pixel);
        #10;
        sys_rst = 1'b0;
        check_outputs();
        drive_inputs();

        // three frames of raster and TMDS
        repeat (RASTER_CYCLES) run_cycle();
        finish_test(0);
        finish_test(1);
        finish_test(2);
        video_checks = 1'b0;

        // low 6 bits pick a start delay of 0 to 63 cycles
        rng_state = xorshift32(rng_state);
        wait_cycles = int'(rng_state[5:0]);
        repeat (wait_cycles) run_cycle();
        pulse_start(3);
        wait_for_done(3);
        repeat (HOLD_CYCLES) run_cycle();
        finish_test(3);

        // restart from done and again mid countdown
        timer_test = 4;
        pulse_start(4);
        rng_state = xorshift32(rng_state);
        wait_cycles = RESTART_GAP + int'(rng_state[5:0]);
        repeat (wait_cycles) run_cycle();
        pulse_start(4);
        wait_for_done(4);
        finish_test(4);
        finish_test(5);

        $display("tests 6, tests with errors %0d, errors %0d", failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/display_pkg.sv
source/video_timing.sv
source/tmds_encoder.sv
source/hdmi_encode.sv
source/game_timer.sv
source/seven_segment_controller.sv
source/display_top.sv
tests/display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the display testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module display_tb -Mdir obj_dir -o display_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/display_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
